// ==== src/hdmi_pkg.sv ====
package hdmi_pkg;

    // ################################################
    // video mode, tiny on purpose
    localparam int H_ACTIVE = 16;
    localparam int H_FP     = 2;
    localparam int H_SYNC   = 4;
    localparam int H_BP     = 2;
    localparam int H_TOTAL  = H_ACTIVE + H_FP + H_SYNC + H_BP;

    localparam int V_ACTIVE = 8;
    localparam int V_FP     = 1;
    localparam int V_SYNC   = 2;
    localparam int V_BP     = 1;
    localparam int V_TOTAL  = V_ACTIVE + V_FP + V_SYNC + V_BP;

    localparam int PIX_DIV  = 2;   // clocks per pixel

    // ################################################
    // framebuffer and register map
    localparam int FB_ADDR_W = 10;

    typedef enum logic [1:0] {
        HDMI_CONFIG = 2'd0,
        HDMI_ADDR   = 2'd1
    } reg_addr_e;

    typedef logic [FB_ADDR_W-1:0] fb_addr_t;
    typedef logic [23:0]          pixel_t;    // r, g, b from the top
    typedef logic [4:0]           hcount_t;
    typedef logic [3:0]           vcount_t;

    typedef struct packed {
        logic enable;
        logic test_pattern;
        logic hsync_pol;   // 1: active high
        logic vsync_pol;
    } hdmi_config_t;

    typedef struct packed {
        logic [15-FB_ADDR_W:0] rsvd;
        fb_addr_t              fb_base;
    } hdmi_addr_t;

    typedef struct packed {
        logic     valid;
        fb_addr_t addr;
        pixel_t   data;
    } fb_wr_t;

    typedef struct packed {
        logic     valid;
        fb_addr_t addr;
    } fb_rd_req_t;

    typedef struct packed {
        logic    pix_en;
        logic    de;
        logic    hsync;   // active high here
        logic    vsync;
        hcount_t x;
        vcount_t y;
    } timing_t;

    typedef struct packed {
        logic   de;
        logic   hsync;
        logic   vsync;
        pixel_t rgb;
    } video_t;

    typedef enum logic [1:0] {
        ACTIVE,
        FRONT,
        SYNC,
        BACK
    } tg_state_e;

endpackage

// ==== src/wishbone_if.sv ====
`timescale 1ns/1ps

// pipelined wishbone, word addressed
interface wishbone_if;

    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] addr;
    logic [3:0]  sel;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        ack;
    logic        stall;
    logic        err;
    logic        rty;

    modport MASTER (
        output cyc, stb, we, addr, sel, wdata,
        input  rdata, ack, stall, err, rty
    );

    modport SLAVE (
        input  cyc, stb, we, addr, sel, wdata,
        output rdata, ack, stall, err, rty
    );

endinterface

// ==== src/reg_bw.sv ====
`timescale 1ns/1ps

module reg_bw #(
    parameter int                 WIDTH       = 32,
    parameter logic [WIDTH-1:0]   RESET_VALUE = '0
) (
    input  logic                       clk_i,
    input  logic                       rstn_i,
    input  logic                       we_i,
    input  logic [(WIDTH+7)/8-1:0]     wsel_i,
    input  logic [WIDTH-1:0]           wdata_i,
    output logic [WIDTH-1:0]           rdata_o
);

    // per bit lane select, so a short top byte needs no extra masking
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            rdata_o <= RESET_VALUE;
        end else if (we_i) begin
            for (int i = 0; i < WIDTH; i++) begin
                if (wsel_i[i/8]) begin
                    rdata_o[i] <= wdata_i[i];
                end
            end
        end
    end

endmodule

// ==== src/hdmi_core_ctrl.sv ====
`timescale 1ns/1ps

module hdmi_core_ctrl (
    input  logic                  clk_i,
    input  logic                  rstn_i,

    wishbone_if.SLAVE             config_if,

    output hdmi_pkg::hdmi_config_t hdmi_config_o,
    output hdmi_pkg::hdmi_addr_t   hdmi_addr_o
);

    logic is_addressed;

    logic [31:0] wb_data_d;
    logic [31:0] wb_data_q;
    logic        ack_q;

    hdmi_pkg::hdmi_config_t hdmi_config_q;
    hdmi_pkg::hdmi_addr_t   hdmi_addr_q;

    logic hdmi_config_we;
    logic hdmi_addr_we;

    assign is_addressed = config_if.cyc & config_if.stb;

    // ################################################
    // address decode
    always_comb begin
        case (config_if.addr)
            hdmi_pkg::HDMI_CONFIG: wb_data_d = 32'(hdmi_config_q);
            hdmi_pkg::HDMI_ADDR:   wb_data_d = 32'(hdmi_addr_q);
            default:               wb_data_d = '0;   // unmapped reads as zero
        endcase
    end

    always_comb begin
        hdmi_config_we = 1'b0;
        hdmi_addr_we   = 1'b0;
        if (is_addressed && config_if.we) begin
            case (config_if.addr)
                hdmi_pkg::HDMI_CONFIG: hdmi_config_we = 1'b1;
                hdmi_pkg::HDMI_ADDR:   hdmi_addr_we   = 1'b1;
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            wb_data_q <= '0;
            ack_q     <= 1'b0;
        end else begin
            wb_data_q <= wb_data_d;
            ack_q     <= is_addressed;   // never stalls
        end
    end

    // ################################################
    // registers
    reg_bw #(
        .WIDTH       ($bits(hdmi_pkg::hdmi_config_t)),
        .RESET_VALUE ('0)
    ) hdmi_config_reg (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .we_i    (hdmi_config_we),
        .wsel_i  (config_if.sel[($bits(hdmi_pkg::hdmi_config_t)+7)/8-1:0]),
        .wdata_i (config_if.wdata[$bits(hdmi_pkg::hdmi_config_t)-1:0]),
        .rdata_o (hdmi_config_q)
    );

    reg_bw #(
        .WIDTH       ($bits(hdmi_pkg::hdmi_addr_t)),
        .RESET_VALUE ('0)
    ) hdmi_addr_reg (
        .clk_i   (clk_i),
        .rstn_i  (rstn_i),
        .we_i    (hdmi_addr_we),
        .wsel_i  (config_if.sel[($bits(hdmi_pkg::hdmi_addr_t)+7)/8-1:0]),
        .wdata_i (config_if.wdata[$bits(hdmi_pkg::hdmi_addr_t)-1:0]),
        .rdata_o (hdmi_addr_q)
    );

    assign config_if.rdata = wb_data_q;
    assign config_if.ack   = ack_q;
    assign config_if.stall = 1'b0;
    assign config_if.err   = 1'b0;
    assign config_if.rty   = 1'b0;

    assign hdmi_config_o = hdmi_config_q;
    assign hdmi_addr_o   = hdmi_addr_q;

    // a write leaves the byte lanes it does not select alone
    a_lane_hold: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (hdmi_addr_we && !config_if.sel[1]) |=> $stable(hdmi_addr_q[15:8]));

endmodule

// ==== src/hdmi_timing_gen.sv ====
`timescale 1ns/1ps

module hdmi_timing_gen (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  hdmi_pkg::hdmi_config_t hdmi_config_i,
    output hdmi_pkg::timing_t      timing_o
);

    logic pix_cnt_q;
    logic pix_last;
    logic line_end;
    logic v_active;

    hdmi_pkg::tg_state_e h_state_q;
    hdmi_pkg::tg_state_e h_state_d;
    hdmi_pkg::hcount_t   h_cnt_q;
    hdmi_pkg::hcount_t   h_end;
    hdmi_pkg::vcount_t   v_cnt_q;

    assign pix_last = (pix_cnt_q == 1'(hdmi_pkg::PIX_DIV - 1));
    assign line_end = (h_state_q == hdmi_pkg::BACK) && (h_cnt_q == h_end);
    assign v_active = (v_cnt_q < hdmi_pkg::vcount_t'(hdmi_pkg::V_ACTIVE));

    // length of each horizontal region and where it goes next
    always_comb begin
        case (h_state_q)
            hdmi_pkg::ACTIVE: begin
                h_end     = hdmi_pkg::hcount_t'(hdmi_pkg::H_ACTIVE - 1);
                h_state_d = hdmi_pkg::FRONT;
            end
            hdmi_pkg::FRONT: begin
                h_end     = hdmi_pkg::hcount_t'(hdmi_pkg::H_FP - 1);
                h_state_d = hdmi_pkg::SYNC;
            end
            hdmi_pkg::SYNC: begin
                h_end     = hdmi_pkg::hcount_t'(hdmi_pkg::H_SYNC - 1);
                h_state_d = hdmi_pkg::BACK;
            end
            default: begin
                h_end     = hdmi_pkg::hcount_t'(hdmi_pkg::H_BP - 1);
                h_state_d = hdmi_pkg::ACTIVE;
            end
        endcase
    end

    // ################################################
    // counters, held at zero while disabled
    always_ff @(posedge clk_i) begin
        if (!rstn_i || !hdmi_config_i.enable) begin
            pix_cnt_q <= 1'b0;
            h_state_q <= hdmi_pkg::ACTIVE;
            h_cnt_q   <= '0;
            v_cnt_q   <= '0;
        end else begin
            pix_cnt_q <= pix_last ? 1'b0 : pix_cnt_q + 1'b1;
            if (pix_last) begin
                if (h_cnt_q == h_end) begin
                    h_cnt_q   <= '0;
                    h_state_q <= h_state_d;
                end else begin
                    h_cnt_q <= h_cnt_q + 1'b1;
                end
                if (line_end) begin
                    v_cnt_q <= (v_cnt_q == hdmi_pkg::vcount_t'(hdmi_pkg::V_TOTAL - 1)) ?
                               '0 : v_cnt_q + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstn_i || !hdmi_config_i.enable) begin
            timing_o <= '0;
        end else begin
            timing_o.pix_en <= (pix_cnt_q == 1'b0);   // first clock of the slot
            timing_o.de     <= (h_state_q == hdmi_pkg::ACTIVE) && v_active;
            timing_o.hsync  <= (h_state_q == hdmi_pkg::SYNC);
            timing_o.vsync  <=
                (v_cnt_q >= hdmi_pkg::vcount_t'(hdmi_pkg::V_ACTIVE + hdmi_pkg::V_FP)) &&
                (v_cnt_q < hdmi_pkg::vcount_t'(hdmi_pkg::V_ACTIVE + hdmi_pkg::V_FP +
                                               hdmi_pkg::V_SYNC));
            timing_o.x      <= (h_state_q == hdmi_pkg::ACTIVE) ? h_cnt_q : '0;
            timing_o.y      <= v_active ? v_cnt_q : '0;
        end
    end

    a_x_in_range: assert property (@(posedge clk_i) disable iff (!rstn_i)
        timing_o.de |-> (timing_o.x < hdmi_pkg::hcount_t'(hdmi_pkg::H_ACTIVE)));

endmodule

// ==== src/fb_mem_arbiter.sv ====
`timescale 1ns/1ps

module fb_mem_arbiter (
    input  logic                 clk_i,
    input  logic                 rstn_i,
    input  hdmi_pkg::fb_rd_req_t rd_req_i,
    output hdmi_pkg::pixel_t     rd_data_o,
    input  hdmi_pkg::fb_wr_t     fb_wr_i
);

    hdmi_pkg::pixel_t mem [2**hdmi_pkg::FB_ADDR_W];

    logic               pend_valid;
    hdmi_pkg::fb_addr_t pend_addr;
    hdmi_pkg::pixel_t   pend_data;
    logic               pend_fire;

    // scanout wins, the host write goes in a free cycle
    assign pend_fire = pend_valid && !rd_req_i.valid;

    // ################################################
    // pending host write
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            pend_valid <= 1'b0;
        end else if (fb_wr_i.valid) begin
            pend_valid <= 1'b1;
        end else if (pend_fire) begin
            pend_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (fb_wr_i.valid) begin
            pend_addr <= fb_wr_i.addr;
            pend_data <= fb_wr_i.data;
        end
    end

    // ################################################
    // ram, one port shared
    always_ff @(posedge clk_i) begin
        if (rd_req_i.valid) begin
            rd_data_o <= mem[rd_req_i.addr];   // holds until the next read
        end else if (pend_fire) begin
            mem[pend_addr] <= pend_data;
        end
    end

    // host pacing: a strobe may only land as the previous write drains
    a_no_overrun: assert property (@(posedge clk_i) disable iff (!rstn_i)
        fb_wr_i.valid |-> (!pend_valid || pend_fire));

    // a write blocked by a read goes out on the next cycle
    a_write_latency: assert property (@(posedge clk_i) disable iff (!rstn_i)
        (pend_valid && !pend_fire) |=> (pend_valid && pend_fire));

endmodule

// ==== src/hdmi_scanout.sv ====
`timescale 1ns/1ps

module hdmi_scanout (
    input  logic                   clk_i,
    input  logic                   rstn_i,
    input  hdmi_pkg::hdmi_config_t hdmi_config_i,
    input  hdmi_pkg::hdmi_addr_t   hdmi_addr_i,
    input  hdmi_pkg::timing_t      timing_i,
    output hdmi_pkg::fb_rd_req_t   rd_req_o,
    input  hdmi_pkg::pixel_t       rd_data_i,
    output hdmi_pkg::video_t       video_o
);

    hdmi_pkg::fb_addr_t line_off;
    hdmi_pkg::timing_t  t1_q;
    logic               pat_q;
    hdmi_pkg::pixel_t   pat_rgb;
    hdmi_pkg::pixel_t   pix_rgb;

    // ################################################
    // stage 0: address request
    assign line_off = hdmi_pkg::fb_addr_t'(timing_i.y) *
                      hdmi_pkg::fb_addr_t'(hdmi_pkg::H_ACTIVE);

    always_comb begin
        rd_req_o.valid = timing_i.pix_en && timing_i.de && !hdmi_config_i.test_pattern;
        // wraps modulo the ram size
        rd_req_o.addr  = hdmi_addr_i.fb_base + line_off + hdmi_pkg::fb_addr_t'(timing_i.x);
    end

    // stage 1: timing waits for the ram
    always_ff @(posedge clk_i) begin
        if (!rstn_i) begin
            t1_q  <= '0;
            pat_q <= 1'b0;
        end else begin
            t1_q  <= timing_i;
            pat_q <= hdmi_config_i.test_pattern;
        end
    end

    // pattern from the delayed coordinates
    always_comb begin
        pat_rgb[23:16] = 8'({t1_q.x, 4'b0000});
        pat_rgb[15:8]  = 8'({t1_q.y, 5'b00000});
        pat_rgb[7:0]   = 8'(t1_q.x ^ hdmi_pkg::hcount_t'(t1_q.y));
    end

    always_comb begin
        if (!t1_q.de) begin
            pix_rgb = '0;
        end else if (pat_q) begin
            pix_rgb = pat_rgb;
        end else begin
            pix_rgb = rd_data_i;
        end
    end

    // ################################################
    // stage 2: output register with polarity
    always_ff @(posedge clk_i) begin
        if (!rstn_i || !hdmi_config_i.enable) begin
            video_o <= '0;   // all quiet while off
        end else begin
            video_o.de    <= t1_q.de;
            video_o.hsync <= t1_q.hsync ~^ hdmi_config_i.hsync_pol;
            video_o.vsync <= t1_q.vsync ~^ hdmi_config_i.vsync_pol;
            video_o.rgb   <= pix_rgb;
        end
    end

endmodule

// ==== src/hdmi_subsys_top.sv ====
`timescale 1ns/1ps

module hdmi_subsys_top (
    input  logic               clk_i,
    input  logic               rstn_i,

    wishbone_if.SLAVE          config_if,

    input  hdmi_pkg::fb_wr_t   fb_wr_i,
    output hdmi_pkg::video_t   video_o
);

    hdmi_pkg::hdmi_config_t hdmi_config;
    hdmi_pkg::hdmi_addr_t   hdmi_addr;
    hdmi_pkg::timing_t      timing;
    hdmi_pkg::fb_rd_req_t   rd_req;
    hdmi_pkg::pixel_t       rd_data;

    // ################################################
    // control and timing
    hdmi_core_ctrl hdmi_core_ctrl_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .config_if     (config_if),
        .hdmi_config_o (hdmi_config),
        .hdmi_addr_o   (hdmi_addr)
    );

    hdmi_timing_gen hdmi_timing_gen_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .hdmi_config_i (hdmi_config),
        .timing_o      (timing)
    );

    // ################################################
    // framebuffer and pixel path
    fb_mem_arbiter fb_mem_arbiter_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .rd_req_i  (rd_req),
        .rd_data_o (rd_data),
        .fb_wr_i   (fb_wr_i)   // host side, no handshake
    );

    hdmi_scanout hdmi_scanout_i (
        .clk_i         (clk_i),
        .rstn_i        (rstn_i),
        .hdmi_config_i (hdmi_config),
        .hdmi_addr_i   (hdmi_addr),
        .timing_i      (timing),
        .rd_req_o      (rd_req),
        .rd_data_i     (rd_data),
        .video_o       (video_o)
    );

endmodule

// ==== dv/hdmi_tb.sv ====
`timescale 1ns/1ps

module hdmi_tb;

    localparam int SEED        = 51422;
    localparam int CLK_HALF    = 4;
    localparam int FRAME_CLKS  = hdmi_pkg::H_TOTAL * hdmi_pkg::V_TOTAL * hdmi_pkg::PIX_DIV;
    localparam int NUM_FRAMES  = 12;
    localparam int REG_OPS     = 40;
    localparam int REG_CYCLES  = REG_OPS * 16;
    localparam int WATCHDOG_CYCLES = (NUM_FRAMES + 4) * FRAME_CLKS + REG_CYCLES;
    localparam int ACK_TIMEOUT = 8;
    localparam int BUF_WORDS   = hdmi_pkg::H_ACTIVE * hdmi_pkg::V_ACTIVE;

    logic             clk_i;
    logic             rstn_i;
    hdmi_pkg::fb_wr_t fb_wr;
    hdmi_pkg::video_t video;

    wishbone_if config_wb ();

    hdmi_subsys_top hdmi_subsys_top_i (
        .clk_i     (clk_i),
        .rstn_i    (rstn_i),
        .config_if (config_wb),
        .fb_wr_i   (fb_wr),
        .video_o   (video)
    );

    // model state
    hdmi_pkg::pixel_t       fb_model [2**hdmi_pkg::FB_ADDR_W];
    hdmi_pkg::hdmi_config_t cfg_model;
    hdmi_pkg::hdmi_addr_t   addr_model;

    int  err_cnt;
    logic mon_on;
    int  de_cnt;     // clocks of de in the current line
    int  line_cnt;
    int  hs_cnt;
    int  vs_cnt;
    int  frame_cnt;

    always #(CLK_HALF) clk_i = ~clk_i;

    // ################################################
    // checks
    task automatic stop_on_error(string msg);
        err_cnt++;
        $display("%s", msg);
        $display("ERRORS FOUND");
        $fatal(1, "stopped at the first error");
    endtask

    task automatic compare_wb_data(string name, logic [31:0] exp, logic [31:0] act);
        if (exp !== act) begin
            stop_on_error($sformatf("FAILED at %0t ns: %s expected %h got %h",
                                    $time, name, exp, act));
        end
    endtask

    task automatic compare_flag(string name, logic exp, logic act);
        if (exp !== act) begin
            stop_on_error($sformatf("FAILED at %0t ns: %s expected %b got %b",
                                    $time, name, exp, act));
        end
    endtask

    task automatic compare_pixel(string name, hdmi_pkg::pixel_t exp, hdmi_pkg::pixel_t act);
        if (exp !== act) begin
            stop_on_error($sformatf("FAILED at %0t ns: %s expected %h got %h",
                                    $time, name, exp, act));
        end
    endtask

    // de, hsync and vsync only
    task automatic compare_sync(string name, hdmi_pkg::video_t exp, hdmi_pkg::video_t act);
        if ({exp.de, exp.hsync, exp.vsync} !== {act.de, act.hsync, act.vsync}) begin
            stop_on_error($sformatf("FAILED at %0t ns: %s expected %b got %b", $time, name,
                                    {exp.de, exp.hsync, exp.vsync},
                                    {act.de, act.hsync, act.vsync}));
        end
    endtask

    task automatic compare_count(string name, int exp, int act);
        if (exp != act) begin
            stop_on_error($sformatf("FAILED at %0t ns: %s expected %0d got %0d",
                                    $time, name, exp, act));
        end
    endtask

    // ################################################
    // reference model
    function automatic logic [31:0] merge_bytes(logic [31:0] old, logic [31:0] wdata,
                                                logic [3:0] sel);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (sel[b]) res[8*b +: 8] = wdata[8*b +: 8];
        end
        return res;
    endfunction

    function automatic void model_reg_write(logic [31:0] addr, logic [31:0] wdata,
                                            logic [3:0] sel);
        logic [31:0] merged;
        if (addr == 32'(hdmi_pkg::HDMI_CONFIG)) begin
            merged    = merge_bytes(32'(cfg_model), wdata, sel);
            cfg_model = hdmi_pkg::hdmi_config_t'(merged[3:0]);
        end else if (addr == 32'(hdmi_pkg::HDMI_ADDR)) begin
            merged     = merge_bytes(32'(addr_model), wdata, sel);
            addr_model = hdmi_pkg::hdmi_addr_t'(merged[15:0]);
        end
    endfunction

    function automatic logic [31:0] expected_read(logic [31:0] addr);
        if (addr == 32'(hdmi_pkg::HDMI_CONFIG)) return 32'(cfg_model);
        if (addr == 32'(hdmi_pkg::HDMI_ADDR)) return 32'(addr_model);
        return '0;   // unmapped
    endfunction

    function automatic hdmi_pkg::pixel_t expected_pixel(int x, int y);
        int idx;
        if (cfg_model.test_pattern) begin
            return {8'(x * 16), 8'(y * 32), 8'(x ^ y)};
        end
        idx = (int'(addr_model.fb_base) + y * hdmi_pkg::H_ACTIVE + x) %
              (2**hdmi_pkg::FB_ADDR_W);
        return fb_model[idx];
    endfunction

    // ################################################
    // bus and host drivers, all called 1 ns after a rising edge
    task automatic wb_transfer(logic we, logic [31:0] addr, logic [31:0] wdata,
                               logic [3:0] sel, output logic [31:0] rdata);
        int waited;
        config_wb.cyc   = 1'b1;
        config_wb.stb   = 1'b1;
        config_wb.we    = we;
        config_wb.addr  = addr;
        config_wb.wdata = wdata;
        config_wb.sel   = sel;
        @(posedge clk_i);   // addressed edge
        #1;
        config_wb.cyc = 1'b0;
        config_wb.stb = 1'b0;
        config_wb.we  = 1'b0;
        waited = 0;
        while (config_wb.ack !== 1'b1) begin
            if (waited == ACK_TIMEOUT) begin
                stop_on_error($sformatf("no wishbone ack for address %0d", addr));
            end
            @(posedge clk_i);
            #1;
            waited++;
        end
        if (waited != 0) begin
            stop_on_error($sformatf("wishbone ack came %0d clocks late", waited));
        end
        compare_flag("wishbone stall", 1'b0, config_wb.stall);
        compare_flag("wishbone err", 1'b0, config_wb.err);
        compare_flag("wishbone rty", 1'b0, config_wb.rty);
        rdata = config_wb.rdata;
    endtask

    task automatic write_reg(logic [31:0] addr, logic [31:0] wdata, logic [3:0] sel);
        logic [31:0] unused;
        wb_transfer(1'b1, addr, wdata, sel, unused);
        model_reg_write(addr, wdata, sel);
    endtask

    task automatic read_and_check(logic [31:0] addr);
        logic [31:0] rd;
        wb_transfer(1'b0, addr, '0, 4'hf, rd);
        compare_wb_data($sformatf("rdata at address %0d", addr), expected_read(addr), rd);
    endtask

    function automatic logic [31:0] pick_reg_addr();
        int r;
        r = $urandom % 4;
        if (r < 2) return 32'(r);
        return 32'(2 + $urandom % 254);
    endfunction

    // one strobe, then a free cycle so strobes sit 2 clocks apart
    task automatic host_write(hdmi_pkg::fb_addr_t addr, hdmi_pkg::pixel_t data);
        fb_wr.valid = 1'b1;
        fb_wr.addr  = addr;
        fb_wr.data  = data;
        fb_model[addr] = data;
        @(posedge clk_i);
        #1;
        fb_wr.valid = 1'b0;
        @(posedge clk_i);
        #1;
    endtask

    task automatic fill_buffer(hdmi_pkg::fb_addr_t base);
        for (int i = 0; i < BUF_WORDS; i++) begin
            host_write(hdmi_pkg::fb_addr_t'(int'(base) + i), hdmi_pkg::pixel_t'($urandom));
        end
    endtask

    task automatic start_video(logic pattern);
        hdmi_pkg::hdmi_config_t cfg;
        cfg.enable       = 1'b1;
        cfg.test_pattern = pattern;
        cfg.hsync_pol    = 1'($urandom);
        cfg.vsync_pol    = 1'($urandom);
        write_reg(32'(hdmi_pkg::HDMI_CONFIG), 32'(cfg), 4'b0001);
        @(posedge clk_i);
        #1;
        de_cnt   = 0;
        line_cnt = 0;
        hs_cnt   = 0;
        vs_cnt   = 0;
        mon_on   = 1'b1;
    endtask

    task automatic stop_video();
        mon_on = 1'b0;
        write_reg(32'(hdmi_pkg::HDMI_CONFIG), '0, 4'b0001);
        repeat (4) @(posedge clk_i);
        #1;
    endtask

    task automatic wait_frames(int n);
        int target;
        target = frame_cnt + n;
        while (frame_cnt < target) begin
            @(posedge clk_i);
            #1;
        end
    endtask

    // ################################################
    // video monitor, sampled mid cycle
    task automatic check_video_sample();
        hdmi_pkg::video_t exp_ctl;
        logic             hs_act;
        logic             vs_act;
        hs_act = (video.hsync == cfg_model.hsync_pol);
        vs_act = (video.vsync == cfg_model.vsync_pol);
        if (video.de) begin
            exp_ctl       = '0;
            exp_ctl.de    = 1'b1;
            exp_ctl.hsync = ~cfg_model.hsync_pol;
            exp_ctl.vsync = ~cfg_model.vsync_pol;
            compare_sync("video_o", exp_ctl, video);
            compare_pixel($sformatf("video_o.rgb x %0d y %0d", de_cnt / 2, line_cnt),
                          expected_pixel(de_cnt / 2, line_cnt), video.rgb);
            de_cnt++;
        end else begin
            compare_pixel("video_o.rgb in blanking", '0, video.rgb);
            if (de_cnt != 0) begin
                compare_count("de clocks per line", hdmi_pkg::H_ACTIVE * hdmi_pkg::PIX_DIV,
                              de_cnt);
                de_cnt = 0;
                line_cnt++;
            end
        end
        if (hs_act) begin
            hs_cnt++;
        end else if (hs_cnt != 0) begin
            compare_count("hsync width", hdmi_pkg::H_SYNC * hdmi_pkg::PIX_DIV, hs_cnt);
            hs_cnt = 0;
        end
        if (vs_act) begin
            if (vs_cnt == 0) begin   // frame boundary
                compare_count("active lines per frame", hdmi_pkg::V_ACTIVE, line_cnt);
                line_cnt = 0;
                frame_cnt++;
            end
            vs_cnt++;
        end else if (vs_cnt != 0) begin
            compare_count("vsync width",
                          hdmi_pkg::V_SYNC * hdmi_pkg::H_TOTAL * hdmi_pkg::PIX_DIV, vs_cnt);
            vs_cnt = 0;
        end
    endtask

    always @(negedge clk_i) begin
        if (mon_on) check_video_sample();
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk_i);
        $display("simulation timed out after %0d clocks", WATCHDOG_CYCLES);
        $display("ERRORS FOUND");
        $fatal(1, "watchdog expired");
    end

    // ################################################
    // test sequence
    initial begin
        hdmi_pkg::fb_addr_t base1;
        hdmi_pkg::fb_addr_t base2;
        logic [31:0]        addr;
        void'($urandom(SEED));
        clk_i = 1'b0;
        rstn_i = 1'b0;
        fb_wr = '0;
        config_wb.cyc = 1'b0;
        config_wb.stb = 1'b0;
        config_wb.we = 1'b0;
        config_wb.addr = '0;
        config_wb.sel = '0;
        config_wb.wdata = '0;
        cfg_model = '0;
        addr_model = '0;
        err_cnt = 0;
        mon_on = 1'b0;
        frame_cnt = 0;
        repeat (10) @(posedge clk_i);
        #1;
        rstn_i = 1'b1;

        // reset values and a quiet output while disabled
        read_and_check(32'(hdmi_pkg::HDMI_CONFIG));
        read_and_check(32'(hdmi_pkg::HDMI_ADDR));
        read_and_check(32'd7);
        repeat (FRAME_CLKS) begin
            @(negedge clk_i);
            compare_sync("video_o while disabled", '0, video);
            compare_pixel("video_o.rgb while disabled", '0, video.rgb);
        end
        @(posedge clk_i);
        #1;

        // random register traffic
        for (int i = 0; i < REG_OPS; i++) begin
            addr = pick_reg_addr();
            write_reg(addr, $urandom, 4'($urandom));
            read_and_check(addr);
            read_and_check(pick_reg_addr());
        end
        stop_video();

        // sync timing on the pattern
        start_video(1'b1);
        wait_frames(2);
        stop_video();

        // scanout of a random buffer at a random base
        base1 = hdmi_pkg::fb_addr_t'($urandom);
        write_reg(32'(hdmi_pkg::HDMI_ADDR), 32'(base1), 4'b0011);
        fill_buffer(base1);
        start_video(1'b0);
        wait_frames(2);
        stop_video();

        // pattern over a filled memory
        start_video(1'b1);
        wait_frames(2);
        stop_video();

        // second buffer written during scanout, switched in vertical blanking
        base2 = hdmi_pkg::fb_addr_t'(int'(base1) + BUF_WORDS);
        start_video(1'b0);
        fill_buffer(base2);
        wait_frames(1);
        write_reg(32'(hdmi_pkg::HDMI_ADDR), 32'(base2), 4'b0011);
        wait_frames(2);
        stop_video();

        if (err_cnt == 0) begin
            $display("NO ERRORS");
        end else begin
            $display("ERRORS FOUND");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
src/hdmi_pkg.sv
src/wishbone_if.sv
src/reg_bw.sv
src/hdmi_core_ctrl.sv
src/hdmi_timing_gen.sv
src/fb_mem_arbiter.sv
src/hdmi_scanout.sv
src/hdmi_subsys_top.sv
dv/hdmi_tb.sv

// ==== Bender.yml ====
package:
  name: hdmi_subsys

sources:
  - files:
      - src/hdmi_pkg.sv
      - src/wishbone_if.sv
      - src/reg_bw.sv
      - src/hdmi_core_ctrl.sv
      - src/hdmi_timing_gen.sv
      - src/fb_mem_arbiter.sv
      - src/hdmi_scanout.sv
      - src/hdmi_subsys_top.sv
  - target: simulation
    files:
      - dv/hdmi_tb.sv
